// ==== list.f ====
+incdir+sim
rtl/rename_pkg.sv
rtl/rename_decode.sv
rtl/free_list.sv
rtl/map_table.sv
rtl/checkpoint_store.sv
rtl/rename_ctrl.sv
rtl/rename_unit.sv
sim/rename_tb.sv

// ==== sim/rename_tb_checks.svh ====
// running totals for the closing line
int check_count   = 0;
int error_count   = 0;
int timeout_count = 0;

task automatic check_src(input string what, input logic [TAG_W-1:0] got,
                         input logic [TAG_W-1:0] exp);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("** Error at %0t ns: %s source tag %0d, expected %0d",
                 $time, what, got, exp);
    end
endtask

// tag and logical index come back together
task automatic check_dst(input string what,
                         input logic [TAG_W-1:0] got_tag, input logic [TAG_W-1:0] exp_tag,
                         input logic [LOG_W-1:0] got_log, input logic [LOG_W-1:0] exp_log);
    check_count++;
    if (got_tag !== exp_tag) begin
        error_count++;
        $display("** Error at %0t ns: %s destination tag %0d, expected %0d",
                 $time, what, got_tag, exp_tag);
    end
    if (got_log !== exp_log) begin
        error_count++;
        $display("** Error at %0t ns: %s destination register %0d, expected %0d",
                 $time, what, got_log, exp_log);
    end
endtask

task automatic check_old(input string what, input logic [TAG_W-1:0] got,
                         input logic [TAG_W-1:0] exp);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("** Error at %0t ns: %s old tag %0d, expected %0d",
                 $time, what, got, exp);
    end
endtask

// ==== sim/rename_tb.sv ====
`timescale 1ns/10ps

module rename_tb import rename_pkg::*; ();

    localparam logic [6:0] OP_REG = 7'b0110011;    // r-type alu
    localparam int ACK_LIMIT = 50;

    logic              clk;
    logic              reset;
    logic              ren_req;
    logic              ren_ack;
    logic              save_req;
    logic              restore_req;
    logic              rel_valid;
    instr_word_u       instr;
    logic [TAG_W-1:0]  src1_tag, src2_tag, dst_tag, old_tag, rel_tag;
    logic [LOG_W-1:0]  dst_log;
    logic [PAGE_W-1:0] page;

    // reference model of the rename state
    logic [TAG_W-1:0] model_map [NUM_LOGICAL];
    logic [TAG_W-1:0] model_free [FL_DEPTH];
    logic [PTR_W-1:0] model_rd, model_wr;
    logic [TAG_W-1:0] saved_map [NUM_PAGES][NUM_LOGICAL];
    logic [PTR_W-1:0] saved_rd [NUM_PAGES];
    logic [TAG_W-1:0] retired [$];    // old tags waiting for release
    logic [31:0]      lcg_state;
    logic [TAG_W-1:0] last_src1, last_src2, last_dst, last_old;
    logic [LOG_W-1:0] last_log;

    `include "rename_tb_checks.svh"

    rename_unit rename_unit_i (
        .clk         (clk),
        .reset       (reset),
        .ren_req     (ren_req),
        .instr       (instr),
        .ren_ack     (ren_ack),
        .src1_tag    (src1_tag),
        .src2_tag    (src2_tag),
        .dst_tag     (dst_tag),
        .dst_log     (dst_log),
        .old_tag     (old_tag),
        .save_req    (save_req),
        .restore_req (restore_req),
        .page        (page),
        .rel_valid   (rel_valid),
        .rel_tag     (rel_tag)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [LOG_W-1:0] rand_reg(input bit nonzero);
        logic [31:0] r;
        r = lcg_next();
        if (nonzero) begin
            return LOG_W'(1 + (r[31:16] % 16'd31));    // x1..x31
        end
        return r[20:16];
    endfunction

    function automatic instr_word_u make_instr(input logic [6:0] op, input logic [LOG_W-1:0] rd,
                                               input logic [LOG_W-1:0] rs1,
                                               input logic [LOG_W-1:0] rs2);
        instr_word_u w;
        w.r.funct7 = 7'd0;
        w.r.rs2    = rs2;
        w.r.rs1    = rs1;
        w.r.funct3 = 3'd0;
        w.r.rd     = rd;
        w.r.opcode = op;
        return w;
    endfunction

    function automatic instr_word_u make_imm_instr(input logic [6:0] op,
                                                   input logic [LOG_W-1:0] rd,
                                                   input logic [LOG_W-1:0] rs1,
                                                   input logic [11:0] imm);
        instr_word_u w;
        w.i.imm12  = imm;
        w.i.rs1    = rs1;
        w.i.funct3 = 3'b010;
        w.i.rd     = rd;
        w.i.opcode = op;
        return w;
    endfunction

    function automatic logic [PTR_W-1:0] free_count();
        return model_wr - model_rd;    // wrap bit makes this 0..32
    endfunction

    task automatic finish_run();
        $display("checks: %0d  errors: %0d  timeouts: %0d",
                 check_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    endtask

    task automatic wait_ack(input logic level);
        int n;
        n = 0;
        while (ren_ack !== level && n < ACK_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (ren_ack !== level) begin
            timeout_count++;
            $display("Timeout at %0t ns: ren_ack never went to %0d", $time, level);
            finish_run();
        end
    endtask

    task automatic release_tag(input logic [TAG_W-1:0] t);
        @(negedge clk);
        rel_valid = 1'b1;
        rel_tag   = t;
        model_free[model_wr[FL_IDX_W-1:0]] = t;
        model_wr++;
        @(negedge clk);
        rel_valid = 1'b0;
    endtask

    // one full handshake; hold > 0 expects a stall that a release ends
    task automatic rename_one(input instr_word_u w, input int hold,
                              input logic [TAG_W-1:0] hold_rel);
        logic [6:0]       op;
        logic             reads1, reads2, writes;
        logic [TAG_W-1:0] exp1, exp2, exp_dst, exp_old;
        op     = w.r.opcode;
        reads1 = !(op == OP_LUI || op == OP_AUIPC || op == OP_JAL);
        reads2 = reads1 && !(op == OP_LOAD || op == OP_IMM || op == OP_JALR);
        writes = !(op == OP_BRANCH || op == OP_STORE) && (w.r.rd != '0);
        @(negedge clk);
        instr   = w;
        ren_req = 1'b1;
        for (int i = 0; i < hold; i++) begin
            @(negedge clk);
            if (ren_ack !== 1'b0) begin
                error_count++;
                $display("** Error at %0t ns: ren_ack rose with no free tag", $time);
            end
        end
        if (hold > 0) begin
            release_tag(hold_rel);
        end
        exp1    = reads1 ? model_map[w.r.rs1] : TAG_NONE_SRC;
        exp2    = reads2 ? model_map[w.r.rs2] : TAG_NONE_SRC;
        exp_dst = writes ? model_free[model_rd[FL_IDX_W-1:0]] : TAG_NONE_DST;
        exp_old = writes ? model_map[w.r.rd] : TAG_NONE_DST;
        wait_ack(1'b1);
        check_src("src1", src1_tag, exp1);
        check_src("src2", src2_tag, exp2);
        check_dst("rename", dst_tag, exp_dst, dst_log, w.r.rd);
        check_old("rename", old_tag, exp_old);
        last_src1 = src1_tag;
        last_src2 = src2_tag;
        last_dst  = dst_tag;
        last_old  = old_tag;
        last_log  = dst_log;
        if (writes) begin
            model_map[w.r.rd] = exp_dst;
            model_rd++;
            retired.push_back(exp_old);
        end
        ren_req = 1'b0;
        wait_ack(1'b0);
    endtask

    task automatic save_page(input logic [PAGE_W-1:0] p);
        @(negedge clk);
        save_req = 1'b1;
        page     = p;
        for (int i = 0; i < NUM_LOGICAL; i++) begin
            saved_map[p][i] = model_map[i];
        end
        saved_rd[p] = model_rd;
        @(negedge clk);
        save_req = 1'b0;
    endtask

    // write side stays put, as in the free list
    task automatic restore_page(input logic [PAGE_W-1:0] p);
        @(negedge clk);
        restore_req = 1'b1;
        page        = p;
        for (int i = 0; i < NUM_LOGICAL; i++) begin
            model_map[i] = saved_map[p][i];
        end
        model_rd = saved_rd[p];
        retired.delete();    // undone renames retire nothing
        @(negedge clk);
        restore_req = 1'b0;
    endtask

    task automatic first_rename();
        rename_one(make_instr(OP_REG, 5'd9, 5'd3, 5'd7), 0, '0);
        check_src("reg 3 after reset", last_src1, 8'd3);
        check_src("reg 7 after reset", last_src2, 8'd7);
        check_dst("first allocation", last_dst, 8'd32, last_log, 5'd9);
        check_old("first allocation", last_old, 8'd9);
    endtask

    task automatic random_renames();
        instr_word_u w;
        for (int k = 0; k < 30; k++) begin
            w = make_instr(OP_REG, rand_reg(1'b1), rand_reg(1'b0), rand_reg(1'b0));
            rename_one(w, 0, '0);
            check_dst("allocation order", last_dst, TAG_W'(33 + k), last_log, w.r.rd);
        end
    endtask

    task automatic unused_operands();
        logic [TAG_W-1:0] nxt;
        nxt = model_free[model_rd[FL_IDX_W-1:0]];
        rename_one(make_imm_instr(OP_LOAD, 5'd0, 5'd2, 12'h040), 0, '0);
        check_src("load rs2", last_src2, TAG_NONE_SRC);
        check_dst("load to x0", last_dst, TAG_NONE_DST, last_log, 5'd0);
        rename_one(make_imm_instr(OP_LUI, 5'd0, 5'd6, 12'h123), 0, '0);
        check_src("lui rs1", last_src1, TAG_NONE_SRC);
        check_src("lui rs2", last_src2, TAG_NONE_SRC);
        rename_one(make_instr(OP_BRANCH, 5'd8, 5'd1, 5'd2), 0, '0);
        check_dst("branch", last_dst, TAG_NONE_DST, last_log, 5'd8);
        rename_one(make_instr(OP_STORE, 5'd12, 5'd3, 5'd4), 0, '0);
        check_dst("store", last_dst, TAG_NONE_DST, last_log, 5'd12);
        rename_one(make_instr(OP_REG, 5'd13, 5'd1, 5'd1), 0, '0);
        check_dst("no tag consumed", last_dst, nxt, last_log, 5'd13);
    endtask

    task automatic checkpoint_restore();
        logic [TAG_W-1:0] nxt;
        repeat (6) release_tag(retired.pop_front());    // list ran dry in the last test
        save_page(4'd5);
        nxt = model_free[model_rd[FL_IDX_W-1:0]];
        rename_one(make_instr(OP_REG, 5'd10, 5'd1, 5'd2), 0, '0);
        rename_one(make_instr(OP_REG, 5'd11, 5'd10, 5'd2), 0, '0);
        rename_one(make_instr(OP_REG, 5'd12, 5'd11, 5'd10), 0, '0);
        restore_page(4'd5);
        rename_one(make_instr(OP_REG, 5'd12, 5'd10, 5'd11), 0, '0);
        check_src("restored reg 10", last_src1, saved_map[5][10]);
        check_src("restored reg 11", last_src2, saved_map[5][11]);
        check_dst("restored free head", last_dst, nxt, last_log, 5'd12);
    endtask

    task automatic empty_backpressure();
        logic [TAG_W-1:0] t;
        while (free_count() != 0) begin
            rename_one(make_instr(OP_REG, rand_reg(1'b1), rand_reg(1'b0), rand_reg(1'b0)),
                       0, '0);
        end
        t = retired.pop_front();
        rename_one(make_instr(OP_REG, 5'd7, 5'd3, 5'd4), 20, t);
        check_dst("after release", last_dst, t, last_log, 5'd7);
    endtask

    task automatic release_order();
        logic [TAG_W-1:0] order [$];
        instr_word_u      w;
        repeat (3) begin
            order.push_back(retired.pop_front());
            release_tag(order[$]);
        end
        w = make_instr(OP_REG, rand_reg(1'b1), rand_reg(1'b0), rand_reg(1'b0));
        rename_one(w, 0, '0);
        check_dst("release order", last_dst, order.pop_front(), last_log, w.r.rd);
        repeat (2) begin
            order.push_back(retired.pop_front());
            release_tag(order[$]);
        end
        repeat (4) begin
            w = make_instr(OP_REG, rand_reg(1'b1), rand_reg(1'b0), rand_reg(1'b0));
            rename_one(w, 0, '0);
            check_dst("release order", last_dst, order.pop_front(), last_log, w.r.rd);
        end
    endtask

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        ren_req     = 1'b0;
        instr       = '0;
        save_req    = 1'b0;
        restore_req = 1'b0;
        page        = '0;
        rel_valid   = 1'b0;
        rel_tag     = '0;
        lcg_state   = 32'h7519d49a;
        for (int i = 0; i < NUM_LOGICAL; i++) begin
            model_map[i] = TAG_W'(i);
        end
        for (int i = 0; i < FL_DEPTH; i++) begin
            model_free[i] = TAG_W'(NUM_LOGICAL + i);
        end
        model_rd = '0;
        model_wr = PTR_W'(FL_DEPTH);
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        first_rename();
        random_renames();
        unused_operands();
        checkpoint_restore();
        empty_backpressure();
        release_order();
        finish_run();
    end

endmodule

// ==== rtl/rename_unit.sv ====
`timescale 1ns/10ps

module rename_unit import rename_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic               ren_req,
    input  instr_word_u        instr,
    output logic               ren_ack,
    output logic [TAG_W-1:0]   src1_tag,
    output logic [TAG_W-1:0]   src2_tag,
    output logic [TAG_W-1:0]   dst_tag,
    output logic [LOG_W-1:0]   dst_log,
    output logic [TAG_W-1:0]   old_tag,
    input  logic               save_req,
    input  logic               restore_req,
    input  logic [PAGE_W-1:0]  page,
    input  logic               rel_valid,
    input  logic [TAG_W-1:0]   rel_tag
);

    logic [LOG_W-1:0]  rs1, rs2, rd;
    logic              use_rs1, use_rs2, has_dst;
    logic              alloc, map_write, empty;
    logic              ckpt_save, ckpt_load;
    logic [TAG_W-1:0]  alloc_tag;
    logic [TAG_W-1:0]  map_src1, map_src2, map_old;    // combinational lookups
    logic [PTR_W-1:0]  rd_ptr, saved_ptr;
    logic [SNAP_W-1:0] snap, saved_table;

    rename_decode rename_decode_i (
        .instr   (instr),
        .rs1     (rs1),
        .rs2     (rs2),
        .rd      (rd),
        .use_rs1 (use_rs1),
        .use_rs2 (use_rs2),
        .has_dst (has_dst)
    );

    rename_ctrl rename_ctrl_i (
        .clk         (clk),
        .reset       (reset),
        .ren_req     (ren_req),
        .save_req    (save_req),
        .restore_req (restore_req),
        .has_dst     (has_dst),
        .empty       (empty),
        .src1_in     (map_src1),
        .src2_in     (map_src2),
        .old_in      (map_old),
        .alloc_tag   (alloc_tag),
        .rd          (rd),
        .alloc       (alloc),
        .map_write   (map_write),
        .ckpt_save   (ckpt_save),
        .ckpt_load   (ckpt_load),
        .ren_ack     (ren_ack),
        .src1_tag    (src1_tag),
        .src2_tag    (src2_tag),
        .dst_tag     (dst_tag),
        .dst_log     (dst_log),
        .old_tag     (old_tag)
    );

    map_table map_table_i (
        .clk        (clk),
        .reset      (reset),
        .rs1        (rs1),
        .rs2        (rs2),
        .rd         (rd),
        .use_rs1    (use_rs1),
        .use_rs2    (use_rs2),
        .src1_tag   (map_src1),
        .src2_tag   (map_src2),
        .old_tag    (map_old),
        .map_write  (map_write),
        .new_tag    (alloc_tag),
        .snap       (snap),
        .load_table (ckpt_load),
        .load_snap  (saved_table)
    );

    free_list free_list_i (
        .clk         (clk),
        .reset       (reset),
        .alloc       (alloc),
        .alloc_tag   (alloc_tag),
        .empty       (empty),
        .rel_valid   (rel_valid),
        .rel_tag     (rel_tag),
        .rd_ptr      (rd_ptr),
        .load_ptr    (ckpt_load),
        .load_rd_ptr (saved_ptr)
    );

    checkpoint_store checkpoint_store_i (
        .clk       (clk),
        .reset     (reset),
        .save      (ckpt_save),
        .page      (page),
        .table_in  (snap),
        .ptr_in    (rd_ptr),
        .table_out (saved_table),
        .ptr_out   (saved_ptr)
    );

endmodule

// ==== rtl/rename_ctrl.sv ====
`timescale 1ns/10ps

module rename_ctrl import rename_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              ren_req,
    input  logic              save_req,
    input  logic              restore_req,
    input  logic              has_dst,
    input  logic              empty,
    input  logic [TAG_W-1:0]  src1_in,
    input  logic [TAG_W-1:0]  src2_in,
    input  logic [TAG_W-1:0]  old_in,
    input  logic [TAG_W-1:0]  alloc_tag,
    input  logic [LOG_W-1:0]  rd,
    output logic              alloc,
    output logic              map_write,
    output logic              ckpt_save,
    output logic              ckpt_load,
    output logic              ren_ack,
    output logic [TAG_W-1:0]  src1_tag,
    output logic [TAG_W-1:0]  src2_tag,
    output logic [TAG_W-1:0]  dst_tag,
    output logic [LOG_W-1:0]  dst_log,
    output logic [TAG_W-1:0]  old_tag
);

    logic [1:0] state;
    logic       waiting;    // request pending, not yet served
    logic       go;         // rename commits at this edge
    logic       idle;

    assign waiting = (state == ST_IDLE) || (state == ST_STALL);
    assign go      = waiting && ren_req && (!has_dst || !empty);
    assign idle    = (state == ST_IDLE) && !ren_req;

    assign alloc     = go && has_dst;
    assign map_write = alloc;
    assign ckpt_save = save_req && idle;
    assign ckpt_load = restore_req && idle;
    assign ren_ack   = (state == ST_ACK);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE, ST_STALL: begin
                    if (go) begin
                        state <= ST_ACK;
                    end else if (ren_req) begin
                        state <= ST_STALL;    // back-pressure on empty list
                    end else begin
                        state <= ST_IDLE;
                    end
                end
                ST_ACK: begin
                    if (!ren_req) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // results held stable for the whole ack phase
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            src1_tag <= TAG_NONE_DST;
            src2_tag <= TAG_NONE_DST;
            dst_tag  <= TAG_NONE_DST;
            old_tag  <= TAG_NONE_DST;
            dst_log  <= '0;
        end else if (go) begin
            src1_tag <= src1_in;
            src2_tag <= src2_in;
            dst_tag  <= has_dst ? alloc_tag : TAG_NONE_DST;
            old_tag  <= has_dst ? old_in : TAG_NONE_DST;
            dst_log  <= rd;
        end
    end

    a_ack_needs_req: assert property (
        @(posedge clk) disable iff (reset) $rose(ren_ack) |-> $past(ren_req)
    ) else $error("rename_ctrl: ack raised without request");

    a_strobe_idle: assert property (
        @(posedge clk) disable iff (reset)
        (save_req || restore_req) |-> (!ren_req && !ren_ack)
    ) else $error("rename_ctrl: save or restore outside idle");

endmodule

// ==== rtl/checkpoint_store.sv ====
`timescale 1ns/10ps

module checkpoint_store import rename_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic               save,
    input  logic [PAGE_W-1:0]  page,
    input  logic [SNAP_W-1:0]  table_in,
    input  logic [PTR_W-1:0]   ptr_in,
    output logic [SNAP_W-1:0]  table_out,
    output logic [PTR_W-1:0]   ptr_out
);

    logic [SNAP_W-1:0]    table_mem [NUM_PAGES];
    logic [PTR_W-1:0]     ptr_mem [NUM_PAGES];
    logic [NUM_PAGES-1:0] page_saved;
    logic [SNAP_W-1:0]    reset_image;    // identity map

    genvar g;
    generate
        for (g = 0; g < NUM_LOGICAL; g++) begin : g_image
            assign reset_image[g*TAG_W +: TAG_W] = TAG_W'(g);
        end
    endgenerate

    // page contents
    always_ff @(posedge clk) begin
        if (save) begin
            table_mem[page] <= table_in;
            ptr_mem[page]   <= ptr_in;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            page_saved <= '0;
        end else if (save) begin
            page_saved[page] <= 1'b1;
        end
    end

    // a page never written reads back as the reset state
    assign table_out = page_saved[page] ? table_mem[page] : reset_image;
    assign ptr_out   = page_saved[page] ? ptr_mem[page]   : '0;

endmodule

// ==== rtl/map_table.sv ====
`timescale 1ns/10ps

module map_table import rename_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic [LOG_W-1:0]   rs1,
    input  logic [LOG_W-1:0]   rs2,
    input  logic [LOG_W-1:0]   rd,
    input  logic               use_rs1,
    input  logic               use_rs2,
    output logic [TAG_W-1:0]   src1_tag,
    output logic [TAG_W-1:0]   src2_tag,
    output logic [TAG_W-1:0]   old_tag,
    input  logic               map_write,
    input  logic [TAG_W-1:0]   new_tag,
    output logic [SNAP_W-1:0]  snap,
    input  logic               load_table,
    input  logic [SNAP_W-1:0]  load_snap
);

    logic [TAG_W-1:0] map_q [NUM_LOGICAL];

    // lookups see the table before this cycle's update
    assign src1_tag = use_rs1 ? map_q[rs1] : TAG_NONE_SRC;
    assign src2_tag = use_rs2 ? map_q[rs2] : TAG_NONE_SRC;
    assign old_tag  = map_q[rd];    // freed later at retirement

    // flatten for the checkpoint pages, entry 0 in the low byte
    genvar g;
    generate
        for (g = 0; g < NUM_LOGICAL; g++) begin : g_snap
            assign snap[g*TAG_W +: TAG_W] = map_q[g];
        end
    endgenerate

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_LOGICAL; i++) begin
                map_q[i] <= TAG_W'(i);    // identity mapping
            end
        end else if (load_table) begin
            for (int i = 0; i < NUM_LOGICAL; i++) begin
                map_q[i] <= load_snap[i*TAG_W +: TAG_W];
            end
        end else if (map_write) begin
            map_q[rd] <= new_tag;
        end
    end

endmodule

// ==== rtl/free_list.sv ====
`timescale 1ns/10ps

module free_list import rename_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              alloc,
    output logic [TAG_W-1:0]  alloc_tag,
    output logic              empty,
    input  logic              rel_valid,
    input  logic [TAG_W-1:0]  rel_tag,
    output logic [PTR_W-1:0]  rd_ptr,
    input  logic              load_ptr,
    input  logic [PTR_W-1:0]  load_rd_ptr
);

    logic [TAG_W-1:0] fifo_mem [FL_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic             full;

    // same index, wrap bits decide full versus empty
    assign empty = (rd_ptr == wr_ptr);
    assign full  = (rd_ptr[FL_IDX_W-1:0] == wr_ptr[FL_IDX_W-1:0]) &&
                   (rd_ptr[PTR_W-1] != wr_ptr[PTR_W-1]);

    assign alloc_tag = fifo_mem[rd_ptr[FL_IDX_W-1:0]];    // head of the list

    // tags 32..63 start out free
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < FL_DEPTH; i++) begin
                fifo_mem[i] <= TAG_W'(NUM_LOGICAL + i);
            end
        end else if (rel_valid) begin
            fifo_mem[wr_ptr[FL_IDX_W-1:0]] <= rel_tag;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= PTR_W'(FL_DEPTH);    // full, wrap bit set
        end else if (rel_valid) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    // Restore rolls back only the read side. Tags released after the
    // checkpoint was taken keep their place behind the write pointer.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_ptr <= '0;
        end else if (load_ptr) begin
            rd_ptr <= load_rd_ptr;
        end else if (alloc) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    a_no_alloc_empty: assert property (
        @(posedge clk) disable iff (reset) alloc |-> !empty
    ) else $error("free_list: allocate while empty");

    a_no_release_full: assert property (
        @(posedge clk) disable iff (reset) rel_valid |-> !full
    ) else $error("free_list: release while full");

endmodule

// ==== rtl/rename_decode.sv ====
`timescale 1ns/10ps

module rename_decode import rename_pkg::*; (
    input  instr_word_u       instr,
    output logic [LOG_W-1:0]  rs1,
    output logic [LOG_W-1:0]  rs2,
    output logic [LOG_W-1:0]  rd,
    output logic              use_rs1,
    output logic              use_rs2,
    output logic              has_dst
);

    logic i_fmt;    // single-source immediate forms
    logic u_fmt;    // no register sources at all
    logic no_rd;    // formats without a destination field

    // register fields sit at the same positions in every format
    assign rs1 = instr.r.rs1;
    assign rs2 = instr.r.rs2;
    assign rd  = instr.r.rd;

    assign i_fmt = (instr.i.opcode == OP_LOAD) ||
                   (instr.i.opcode == OP_IMM)  ||
                   (instr.i.opcode == OP_JALR);

    always_comb begin
        u_fmt = 1'b0;
        no_rd = 1'b0;
        case (instr.r.opcode)
            OP_LUI, OP_AUIPC, OP_JAL: begin
                u_fmt = 1'b1;
            end
            OP_BRANCH, OP_STORE: begin
                no_rd = 1'b1;    // both sources read, nothing written
            end
            default: begin
                u_fmt = 1'b0;    // r-type and anything unknown
            end
        endcase
    end

    assign use_rs1 = !u_fmt;
    assign use_rs2 = !u_fmt && !i_fmt;
    assign has_dst = !no_rd && (rd != '0);    // x0 is never renamed

endmodule

// ==== rtl/rename_pkg.sv ====
package rename_pkg;

    // architectural and physical sizes
    localparam int NUM_LOGICAL = 32;
    localparam int NUM_PHYS    = 64;
    localparam int TAG_W       = 8;             // tags carried as bytes
    localparam int LOG_W       = 5;
    localparam int NUM_PAGES   = 16;
    localparam int PAGE_W      = 4;
    localparam int PTR_W       = 6;             // index plus wrap bit

    // free list holds every tag not covered by the reset mapping
    localparam int FL_DEPTH    = NUM_PHYS - NUM_LOGICAL;
    localparam int FL_IDX_W    = PTR_W - 1;

    // full map table flattened into one vector
    localparam int SNAP_W      = NUM_LOGICAL * TAG_W;

    // reserved tag values outside the physical range
    localparam logic [TAG_W-1:0] TAG_NONE_SRC = 8'd254;    // operand not read
    localparam logic [TAG_W-1:0] TAG_NONE_DST = 8'd255;    // no destination

    // rv32i major opcodes
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;

    // rename controller states
    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_STALL = 2'd1;    // request held, no free tag
    localparam logic [1:0] ST_ACK   = 2'd2;    // ack high until req drops

    // one instruction word, two field layouts over the same bits
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
    } instr_word_u;

endpackage
